// ==== list.f ====
mc_link_pkg.sv
mc_net_pkg.sv
mc_link_master.sv
mc_bus_fabric.sv
mc_mem_endpoint.sv
mc_gateway_node.sv
tb_gateway_checker.sv
tb_gateway.sv

// ==== Bender.yml ====
package:
  name: mc_gateway_node

sources:
  # Packages first, then the design from leaves to top
  - mc_link_pkg.sv
  - mc_net_pkg.sv
  - mc_link_master.sv
  - mc_bus_fabric.sv
  - mc_mem_endpoint.sv
  - mc_gateway_node.sv

  - target: test
    files:
      - tb_gateway_checker.sv
      - tb_gateway.sv

// ==== tb_gateway.sv ====
`timescale 1ns/1ps

module tb_gateway;

  localparam int reqs_per_port_lp  = 200;
  localparam int timeout_cycles_lp = reqs_per_port_lp * 2 * 20;
  localparam int hold_start_lp     = 40;
  localparam int hold_cycles_lp    = 30;
  localparam int drive_delay_lp    = 5;

  logic blackparrot_clk;
  logic reset_i;

  // Index 0 is the host port and index 1 the tile port
  logic                    req_v     [2];
  mc_link_pkg::mc_op_t     req_op    [2];
  mc_link_pkg::mc_x_cord_t req_x     [2];
  mc_link_pkg::mc_y_cord_t req_y     [2];
  mc_link_pkg::mc_addr_t   req_addr  [2];
  mc_link_pkg::mc_data_t   req_data  [2];
  logic                    rsp_ready [2];

  logic                    host_req_ready;
  logic                    host_rsp_v;
  mc_link_pkg::mc_op_t     host_rsp_op;
  logic                    host_rsp_err;
  mc_link_pkg::mc_data_t   host_rsp_data;
  logic                    tile_req_ready;
  logic                    tile_rsp_v;
  mc_link_pkg::mc_op_t     tile_rsp_op;
  logic                    tile_rsp_err;
  mc_link_pkg::mc_data_t   tile_rsp_data;

  logic [31:0] rng_state;
  // Addresses each port has stored in each endpoint
  logic        written [2][4][128];
  int          cycle_count;
  int          host_mismatches;
  int          tile_mismatches;
  int          host_other;
  int          tile_other;
  int          host_pending;
  int          tile_pending;
  logic        host_stall_seen;

  mc_gateway_node dut0
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.host_req_v_i(req_v[0]), .host_req_op_i(req_op[0])
    ,.host_req_x_i(req_x[0]), .host_req_y_i(req_y[0])
    ,.host_req_addr_i(req_addr[0]), .host_req_data_i(req_data[0])
    ,.host_req_ready_o(host_req_ready)
    ,.host_rsp_v_o(host_rsp_v), .host_rsp_op_o(host_rsp_op)
    ,.host_rsp_err_o(host_rsp_err), .host_rsp_data_o(host_rsp_data)
    ,.host_rsp_ready_i(rsp_ready[0])
    ,.tile_req_v_i(req_v[1]), .tile_req_op_i(req_op[1])
    ,.tile_req_x_i(req_x[1]), .tile_req_y_i(req_y[1])
    ,.tile_req_addr_i(req_addr[1]), .tile_req_data_i(req_data[1])
    ,.tile_req_ready_o(tile_req_ready)
    ,.tile_rsp_v_o(tile_rsp_v), .tile_rsp_op_o(tile_rsp_op)
    ,.tile_rsp_err_o(tile_rsp_err), .tile_rsp_data_o(tile_rsp_data)
    ,.tile_rsp_ready_i(rsp_ready[1])
    );

  tb_gateway_checker #(.port_name_p("host")) host_check
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.req_v_i(req_v[0]), .req_op_i(req_op[0]), .req_x_i(req_x[0]), .req_y_i(req_y[0])
    ,.req_addr_i(req_addr[0]), .req_data_i(req_data[0]), .req_ready_i(host_req_ready)
    ,.rsp_v_i(host_rsp_v), .rsp_op_i(host_rsp_op), .rsp_err_i(host_rsp_err)
    ,.rsp_data_i(host_rsp_data), .rsp_ready_i(rsp_ready[0])
    ,.other_rsp_fire_i(tile_rsp_v & rsp_ready[1])
    ,.mismatch_count_o(host_mismatches), .other_count_o(host_other)
    ,.pending_o(host_pending), .stall_seen_o(host_stall_seen)
    );

  tb_gateway_checker #(.port_name_p("tile")) tile_check
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.req_v_i(req_v[1]), .req_op_i(req_op[1]), .req_x_i(req_x[1]), .req_y_i(req_y[1])
    ,.req_addr_i(req_addr[1]), .req_data_i(req_data[1]), .req_ready_i(tile_req_ready)
    ,.rsp_v_i(tile_rsp_v), .rsp_op_i(tile_rsp_op), .rsp_err_i(tile_rsp_err)
    ,.rsp_data_i(tile_rsp_data), .rsp_ready_i(rsp_ready[1])
    ,.other_rsp_fire_i(host_rsp_v & rsp_ready[0])
    ,.mismatch_count_o(tile_mismatches), .other_count_o(tile_other)
    ,.pending_o(tile_pending), .stall_seen_o()
    );

  initial blackparrot_clk = 1'b0;
  always #50 blackparrot_clk = ~blackparrot_clk;

  always @(posedge blackparrot_clk)
    begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles_lp)
        begin
          $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
          $display("TESTBENCH FAILED");
          $finish;
        end
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Request generation

  // First eight requests store then load once per endpoint
  task automatic build_request(input int p, input int n);
    logic [31:0] r;
    logic [1:0]  ep;
    logic [6:0]  off;
    logic        mapped;
    r           = draw_random();
    req_data[p] = draw_random();
    if (n < 8)
      begin
        ep        = n[2:1];
        off       = 7'd5;
        mapped    = 1'b1;
        req_op[p] = n[0] ? mc_link_pkg::mc_op_load_lp : mc_link_pkg::mc_op_store_lp;
      end
    else
      begin
        ep        = r[1:0];
        off       = r[8:2];
        mapped    = (r[11:9] != 3'd0);
        req_op[p] = r[12] ? mc_link_pkg::mc_op_store_lp : mc_link_pkg::mc_op_load_lp;
        if (mapped && req_op[p] == mc_link_pkg::mc_op_load_lp && !written[p][ep][off])
          req_op[p] = mc_link_pkg::mc_op_store_lp;
      end
    if (mapped)
      begin
        req_x[p] = {1'b0, ep[0]} + 2'd1;
        req_y[p] = ep[1] ? 2'd3 : 2'd0;
        if (req_op[p] == mc_link_pkg::mc_op_store_lp)
          written[p][ep][off] = 1'b1;
      end
    else
      begin
        // Middle rows only when the column holds memories
        req_x[p] = r[14:13];
        req_y[p] = (r[14:13] == 2'd1 || r[14:13] == 2'd2) ? {~r[15], r[15]} : r[16:15];
      end
    req_addr[p] = {p[0], off};
    req_v[p]    = 1'b1;
  endtask

  initial
    begin
      int   sent [2];
      logic fire [2];
      int   hold_left;
      logic hold_started;
      int   total_mismatches;
      int   total_other;

      rng_state    = 32'h7f1d5284;
      cycle_count  = 0;
      reset_i      = 1'b1;
      hold_left    = 0;
      hold_started = 1'b0;
      for (int p = 0; p < 2; p++)
        begin
          req_v[p]     = 1'b0;
          req_op[p]    = mc_link_pkg::mc_op_load_lp;
          req_x[p]     = '0;
          req_y[p]     = '0;
          req_addr[p]  = '0;
          req_data[p]  = '0;
          rsp_ready[p] = 1'b0;
          sent[p]      = 0;
          fire[p]      = 1'b0;
          for (int e = 0; e < 4; e++)
            for (int a = 0; a < 128; a++)
              written[p][e][a] = 1'b0;
        end

      repeat (4) @(posedge blackparrot_clk);
      #(drive_delay_lp);
      reset_i = 1'b0;

      while (!(sent[0] == reqs_per_port_lp && sent[1] == reqs_per_port_lp
               && host_pending == 0 && tile_pending == 0))
        begin
          @(posedge blackparrot_clk);
          fire[0] = req_v[0] && host_req_ready;
          fire[1] = req_v[1] && tile_req_ready;
          #(drive_delay_lp);
          for (int p = 0; p < 2; p++)
            if (fire[p])
              begin
                sent[p]  = sent[p] + 1;
                req_v[p] = 1'b0;
              end
          // Hold host responses while the tile port keeps running
          if (sent[0] == hold_start_lp && !hold_started)
            begin
              hold_started = 1'b1;
              hold_left    = hold_cycles_lp;
            end
          for (int p = 0; p < 2; p++)
            if (!req_v[p] && sent[p] < reqs_per_port_lp)
              if ((hold_left > 0 && p == 0) || (draw_random() & 32'd3) != 0)
                build_request(p, sent[p]);
          if (hold_left > 0)
            begin
              rsp_ready[0] = 1'b0;
              rsp_ready[1] = 1'b1;
              hold_left    = hold_left - 1;
            end
          else
            begin
              rsp_ready[0] = ((draw_random() & 32'd3) != 0);
              rsp_ready[1] = ((draw_random() & 32'd3) != 0);
            end
        end

      repeat (4) @(posedge blackparrot_clk);

      total_mismatches = host_mismatches + tile_mismatches;
      total_other      = host_other + tile_other;
      if (!host_stall_seen)
        begin
          $display("Host responses were never held long enough to check back-pressure");
          total_other = total_other + 1;
        end
      $display("Errors: %0d mismatches, %0d other failures", total_mismatches, total_other);
      if (total_mismatches == 0 && total_other == 0)
        $display("TESTBENCH PASSED");
      else
        $display("TESTBENCH FAILED");
      $finish;
    end

endmodule

// ==== tb_gateway_checker.sv ====
`timescale 1ns/1ps

module tb_gateway_checker
  #(parameter port_name_p = "host")
  (input                            blackparrot_clk
  ,input                            reset_i

  ,input                            req_v_i
  ,input  mc_link_pkg::mc_op_t      req_op_i
  ,input  mc_link_pkg::mc_x_cord_t  req_x_i
  ,input  mc_link_pkg::mc_y_cord_t  req_y_i
  ,input  mc_link_pkg::mc_addr_t    req_addr_i
  ,input  mc_link_pkg::mc_data_t    req_data_i
  ,input                            req_ready_i

  ,input                            rsp_v_i
  ,input  mc_link_pkg::mc_op_t      rsp_op_i
  ,input                            rsp_err_i
  ,input  mc_link_pkg::mc_data_t    rsp_data_i
  ,input                            rsp_ready_i
  ,input                            other_rsp_fire_i

  ,output int                       mismatch_count_o
  ,output int                       other_count_o
  ,output int                       pending_o
  ,output logic                     stall_seen_o
  );

  // Expected responses in request order, as {op, err, data}
  logic [33:0] expect_q [$];

  mc_link_pkg::mc_data_t model_mem [4][256];

  logic        reset_seen;
  logic        held_v;
  logic [33:0] held_rsp;
  int          stall_run;
  int          other_rsp_run;

  // Mapped flag and endpoint index
  function automatic logic [2:0] decode_target(input mc_link_pkg::mc_x_cord_t x,
                                               input mc_link_pkg::mc_y_cord_t y);
    logic       mapped;
    logic [1:0] ep;
    mapped = (x == 2'd1 || x == 2'd2) && (y == 2'd0 || y == 2'd3);
    ep     = (x - 2'd1) + ((y == 2'd3) ? 2'd2 : 2'd0);
    return {mapped, ep};
  endfunction

  function automatic logic [33:0] reference_rsp(input mc_link_pkg::mc_op_t     op,
                                                input mc_link_pkg::mc_x_cord_t x,
                                                input mc_link_pkg::mc_y_cord_t y,
                                                input mc_link_pkg::mc_addr_t   addr);
    logic [2:0]            target;
    mc_link_pkg::mc_data_t data;
    target = decode_target(x, y);
    data   = '0;
    if (target[2] && op == mc_link_pkg::mc_op_load_lp)
      data = model_mem[target[1:0]][addr];
    return {op, ~target[2], data};
  endfunction

  always @(posedge blackparrot_clk)
    begin : watch
      logic [33:0] exp_rsp;
      logic [33:0] got_rsp;
      logic [2:0]  target;
      got_rsp = {rsp_op_i, rsp_err_i, rsp_data_i};
      if (reset_i)
        begin
          reset_seen       = 1'b1;
          held_v           = 1'b0;
          stall_run        = 0;
          other_rsp_run    = 0;
          mismatch_count_o = 0;
          other_count_o    = 0;
          pending_o        = 0;
          stall_seen_o     = 1'b0;
          expect_q.delete();
        end
      else
        begin
          if (reset_seen)
            begin
              reset_seen = 1'b0;
              if (req_ready_i !== 1'b1 || rsp_v_i !== 1'b0)
                begin
                  $display("Mismatch at %0t: %s port after reset req_ready_o=%b rsp_v_o=%b",
                           $time, port_name_p, req_ready_i, rsp_v_i);
                  mismatch_count_o = mismatch_count_o + 1;
                end
            end

          if (held_v && (rsp_v_i !== 1'b1 || got_rsp !== held_rsp))
            begin
              $display("Mismatch at %0t: %s response changed while held, v=%b now %h was %h",
                       $time, port_name_p, rsp_v_i, got_rsp, held_rsp);
              mismatch_count_o = mismatch_count_o + 1;
            end
          held_v   = rsp_v_i && !rsp_ready_i;
          held_rsp = got_rsp;

          ////////////////////////////////////////////////////////////////////
          // Response compare

          if (rsp_v_i && rsp_ready_i)
            begin
              if (expect_q.size() == 0)
                begin
                  $display("The %s port returned a response with no request outstanding at %0t",
                           port_name_p, $time);
                  other_count_o = other_count_o + 1;
                end
              else
                begin
                  exp_rsp = expect_q.pop_front();
                  if (got_rsp !== exp_rsp)
                    begin
                      $display("Mismatch at %0t: %s op=%0d err=%0d data=%h, expected %0d %0d %h",
                               $time, port_name_p, got_rsp[33], got_rsp[32], got_rsp[31:0],
                               exp_rsp[33], exp_rsp[32], exp_rsp[31:0]);
                      mismatch_count_o = mismatch_count_o + 1;
                    end
                end
            end

          // Held response with requests waiting
          if (rsp_v_i && !rsp_ready_i && req_v_i)
            begin
              if (stall_run >= 4 && req_ready_i)
                begin
                  $display("The %s port still accepts requests after %0d held cycles at %0t",
                           port_name_p, stall_run, $time);
                  other_count_o = other_count_o + 1;
                end
              stall_run = stall_run + 1;
              if (other_rsp_fire_i)
                other_rsp_run = other_rsp_run + 1;
              if (stall_run == 16)
                begin
                  stall_seen_o = 1'b1;
                  if (other_rsp_run == 0)
                    begin
                      $display("The other port delivered nothing while %s was held at %0t",
                               port_name_p, $time);
                      other_count_o = other_count_o + 1;
                    end
                end
            end
          else
            begin
              stall_run     = 0;
              other_rsp_run = 0;
            end

          if (req_v_i && req_ready_i)
            begin
              expect_q.push_back(reference_rsp(req_op_i, req_x_i, req_y_i, req_addr_i));
              target = decode_target(req_x_i, req_y_i);
              if (target[2] && req_op_i == mc_link_pkg::mc_op_store_lp)
                model_mem[target[1:0]][req_addr_i] = req_data_i;
            end
          pending_o = expect_q.size();
        end
    end

endmodule

// ==== mc_gateway_node.sv ====
`timescale 1ns/1ps

module mc_gateway_node
  (input                            blackparrot_clk
  ,input                            reset_i

  // Host loader port
  ,input                            host_req_v_i
  ,input  mc_link_pkg::mc_op_t      host_req_op_i
  ,input  mc_link_pkg::mc_x_cord_t  host_req_x_i
  ,input  mc_link_pkg::mc_y_cord_t  host_req_y_i
  ,input  mc_link_pkg::mc_addr_t    host_req_addr_i
  ,input  mc_link_pkg::mc_data_t    host_req_data_i
  ,output logic                     host_req_ready_o
  ,output logic                     host_rsp_v_o
  ,output mc_link_pkg::mc_op_t      host_rsp_op_o
  ,output logic                     host_rsp_err_o
  ,output mc_link_pkg::mc_data_t    host_rsp_data_o
  ,input                            host_rsp_ready_i

  // Processor tile port
  ,input                            tile_req_v_i
  ,input  mc_link_pkg::mc_op_t      tile_req_op_i
  ,input  mc_link_pkg::mc_x_cord_t  tile_req_x_i
  ,input  mc_link_pkg::mc_y_cord_t  tile_req_y_i
  ,input  mc_link_pkg::mc_addr_t    tile_req_addr_i
  ,input  mc_link_pkg::mc_data_t    tile_req_data_i
  ,output logic                     tile_req_ready_o
  ,output logic                     tile_rsp_v_o
  ,output mc_link_pkg::mc_op_t      tile_rsp_op_o
  ,output logic                     tile_rsp_err_o
  ,output mc_link_pkg::mc_data_t    tile_rsp_data_o
  ,input                            tile_rsp_ready_i
  );

  logic [mc_net_pkg::mc_num_masters_lp-1:0] m_cyc;
  logic [mc_net_pkg::mc_num_masters_lp-1:0] m_stb;
  logic [mc_net_pkg::mc_num_masters_lp-1:0] m_we;
  logic [mc_net_pkg::mc_num_masters_lp-1:0] m_ack;
  logic [mc_net_pkg::mc_num_masters_lp-1:0] m_err;
  mc_link_pkg::mc_x_cord_t [mc_net_pkg::mc_num_masters_lp-1:0] m_x;
  mc_link_pkg::mc_y_cord_t [mc_net_pkg::mc_num_masters_lp-1:0] m_y;
  mc_link_pkg::mc_addr_t   [mc_net_pkg::mc_num_masters_lp-1:0] m_adr;
  mc_link_pkg::mc_data_t   [mc_net_pkg::mc_num_masters_lp-1:0] m_dat_w;
  mc_link_pkg::mc_data_t   [mc_net_pkg::mc_num_masters_lp-1:0] m_dat_r;

  logic [mc_net_pkg::mc_num_endpoints_lp-1:0] ep_stb;
  logic [mc_net_pkg::mc_num_endpoints_lp-1:0] ep_ack;
  logic                                      ep_we;
  mc_link_pkg::mc_addr_t                     ep_adr;
  mc_link_pkg::mc_data_t                     ep_dat_w;
  mc_link_pkg::mc_data_t [mc_net_pkg::mc_num_endpoints_lp-1:0] ep_dat_r;

  ////////////////////////////////////////////////////////////////////
  // Port masters

  mc_link_master master0
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.req_v_i(host_req_v_i), .req_op_i(host_req_op_i)
    ,.req_x_i(host_req_x_i), .req_y_i(host_req_y_i)
    ,.req_addr_i(host_req_addr_i), .req_data_i(host_req_data_i)
    ,.req_ready_o(host_req_ready_o)
    ,.rsp_v_o(host_rsp_v_o), .rsp_op_o(host_rsp_op_o)
    ,.rsp_err_o(host_rsp_err_o), .rsp_data_o(host_rsp_data_o)
    ,.rsp_ready_i(host_rsp_ready_i)
    ,.wb_cyc_o(m_cyc[0]), .wb_stb_o(m_stb[0]), .wb_we_o(m_we[0])
    ,.wb_x_o(m_x[0]), .wb_y_o(m_y[0]), .wb_adr_o(m_adr[0]), .wb_dat_o(m_dat_w[0])
    ,.wb_ack_i(m_ack[0]), .wb_err_i(m_err[0]), .wb_dat_i(m_dat_r[0])
    );

  mc_link_master master1
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.req_v_i(tile_req_v_i), .req_op_i(tile_req_op_i)
    ,.req_x_i(tile_req_x_i), .req_y_i(tile_req_y_i)
    ,.req_addr_i(tile_req_addr_i), .req_data_i(tile_req_data_i)
    ,.req_ready_o(tile_req_ready_o)
    ,.rsp_v_o(tile_rsp_v_o), .rsp_op_o(tile_rsp_op_o)
    ,.rsp_err_o(tile_rsp_err_o), .rsp_data_o(tile_rsp_data_o)
    ,.rsp_ready_i(tile_rsp_ready_i)
    ,.wb_cyc_o(m_cyc[1]), .wb_stb_o(m_stb[1]), .wb_we_o(m_we[1])
    ,.wb_x_o(m_x[1]), .wb_y_o(m_y[1]), .wb_adr_o(m_adr[1]), .wb_dat_o(m_dat_w[1])
    ,.wb_ack_i(m_ack[1]), .wb_err_i(m_err[1]), .wb_dat_i(m_dat_r[1])
    );

  ////////////////////////////////////////////////////////////////////
  // Shared bus

  mc_bus_fabric fabric0
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we)
    ,.m_x_i(m_x), .m_y_i(m_y), .m_adr_i(m_adr), .m_dat_i(m_dat_w)
    ,.m_ack_o(m_ack), .m_err_o(m_err), .m_dat_o(m_dat_r)
    ,.ep_stb_o(ep_stb), .ep_we_o(ep_we), .ep_adr_o(ep_adr), .ep_dat_o(ep_dat_w)
    ,.ep_ack_i(ep_ack), .ep_dat_i(ep_dat_r)
    );

  // North row, columns 1 and 2
  mc_mem_endpoint mem_ep0
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.stb_i(ep_stb[0]), .we_i(ep_we), .adr_i(ep_adr), .dat_i(ep_dat_w)
    ,.ack_o(ep_ack[0]), .dat_o(ep_dat_r[0])
    );

  mc_mem_endpoint mem_ep1
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.stb_i(ep_stb[1]), .we_i(ep_we), .adr_i(ep_adr), .dat_i(ep_dat_w)
    ,.ack_o(ep_ack[1]), .dat_o(ep_dat_r[1])
    );

  // South row
  mc_mem_endpoint mem_ep2
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.stb_i(ep_stb[2]), .we_i(ep_we), .adr_i(ep_adr), .dat_i(ep_dat_w)
    ,.ack_o(ep_ack[2]), .dat_o(ep_dat_r[2])
    );

  mc_mem_endpoint mem_ep3
    (.blackparrot_clk(blackparrot_clk), .reset_i(reset_i)
    ,.stb_i(ep_stb[3]), .we_i(ep_we), .adr_i(ep_adr), .dat_i(ep_dat_w)
    ,.ack_o(ep_ack[3]), .dat_o(ep_dat_r[3])
    );

endmodule

// ==== mc_mem_endpoint.sv ====
`timescale 1ns/1ps

module mc_mem_endpoint
  (input                           blackparrot_clk
  ,input                           reset_i

  ,input                           stb_i
  ,input                           we_i
  ,input  mc_link_pkg::mc_addr_t   adr_i
  ,input  mc_link_pkg::mc_data_t   dat_i

  ,output logic                    ack_o
  ,output mc_link_pkg::mc_data_t   dat_o
  );

  mc_link_pkg::mc_data_t mem_r [mc_net_pkg::mc_mem_els_lp];

  logic ack_r;
  logic access;
  mc_link_pkg::mc_data_t rd_data_r;

  // Strobe still high during ack must not repeat the access
  assign access = stb_i & ~ack_r;

  always_ff @(posedge blackparrot_clk)
    begin
      if (reset_i)
        ack_r <= 1'b0;
      else
        ack_r <= access;
    end

  ////////////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge blackparrot_clk)
    begin
      if (access)
        begin
          if (we_i)
            mem_r[adr_i] <= dat_i;
          rd_data_r <= mem_r[adr_i];
        end
    end

  assign ack_o = ack_r;
  assign dat_o = rd_data_r;

endmodule

// ==== mc_bus_fabric.sv ====
`timescale 1ns/1ps

module mc_bus_fabric
  (input                                                              blackparrot_clk
  ,input                                                              reset_i

  ,input        [mc_net_pkg::mc_num_masters_lp-1:0]                   m_cyc_i
  ,input        [mc_net_pkg::mc_num_masters_lp-1:0]                   m_stb_i
  ,input        [mc_net_pkg::mc_num_masters_lp-1:0]                   m_we_i
  ,input  mc_link_pkg::mc_x_cord_t [mc_net_pkg::mc_num_masters_lp-1:0] m_x_i
  ,input  mc_link_pkg::mc_y_cord_t [mc_net_pkg::mc_num_masters_lp-1:0] m_y_i
  ,input  mc_link_pkg::mc_addr_t   [mc_net_pkg::mc_num_masters_lp-1:0] m_adr_i
  ,input  mc_link_pkg::mc_data_t   [mc_net_pkg::mc_num_masters_lp-1:0] m_dat_i
  ,output logic [mc_net_pkg::mc_num_masters_lp-1:0]                   m_ack_o
  ,output logic [mc_net_pkg::mc_num_masters_lp-1:0]                   m_err_o
  ,output mc_link_pkg::mc_data_t   [mc_net_pkg::mc_num_masters_lp-1:0] m_dat_o

  ,output logic [mc_net_pkg::mc_num_endpoints_lp-1:0]                 ep_stb_o
  ,output logic                                                       ep_we_o
  ,output mc_link_pkg::mc_addr_t                                      ep_adr_o
  ,output mc_link_pkg::mc_data_t                                      ep_dat_o
  ,input        [mc_net_pkg::mc_num_endpoints_lp-1:0]                 ep_ack_i
  ,input  mc_link_pkg::mc_data_t [mc_net_pkg::mc_num_endpoints_lp-1:0] ep_dat_i
  );

  localparam int num_m_lp      = mc_net_pkg::mc_num_masters_lp;
  localparam int id_width_lp   = (num_m_lp > 1) ? $clog2(num_m_lp) : 1;

  // Granted master, kept as the last served one once released
  logic                    gnt_v_r;
  logic [id_width_lp-1:0]  gnt_id_r;
  logic                    pick_v;
  logic [id_width_lp-1:0]  pick_id;
  logic                    err_r;
  logic                    ack_any;
  logic                    done;

  mc_link_pkg::mc_x_cord_t sel_x;
  mc_link_pkg::mc_y_cord_t sel_y;
  logic                    col_hit;
  logic                    row_south;
  logic                    hit;
  mc_net_pkg::mc_ep_id_t   ep_id;

  ////////////////////////////////////////////////////////////////////
  // Round-robin arbitration

  // Search starts just after the last served master
  always_comb
    begin
      int idx;
      pick_v  = 1'b0;
      pick_id = gnt_id_r;
      for (int i = 1; i <= num_m_lp; i++)
        begin
          idx = (int'(gnt_id_r) + i) % num_m_lp;
          if (!pick_v && m_cyc_i[idx])
            begin
              pick_v  = 1'b1;
              pick_id = id_width_lp'(idx);
            end
        end
    end

  assign ack_any = |ep_ack_i;
  assign done    = gnt_v_r & (ack_any | err_r);

  always_ff @(posedge blackparrot_clk)
    begin
      if (reset_i)
        begin
          gnt_v_r  <= 1'b0;
          gnt_id_r <= '0;
          err_r    <= 1'b0;
        end
      else
        begin
          if (done)
            gnt_v_r <= 1'b0;
          else if (!gnt_v_r && pick_v)
            begin
              gnt_v_r  <= 1'b1;
              gnt_id_r <= pick_id;
            end
          // Unmapped target answers with a single err pulse
          err_r <= gnt_v_r & ~hit & ~err_r;
        end
    end

  ////////////////////////////////////////////////////////////////////
  // Coordinate decode

  assign sel_x     = m_x_i[gnt_id_r];
  assign sel_y     = m_y_i[gnt_id_r];
  assign col_hit   = (sel_x >= 1) && (sel_x <= mc_net_pkg::mc_num_tiles_x_lp);
  assign row_south = (sel_y == mc_net_pkg::mc_south_y_lp);
  assign hit       = col_hit && ((sel_y == mc_net_pkg::mc_north_y_lp) || row_south);
  assign ep_id     = mc_net_pkg::mc_ep_id_t'(sel_x - 1'b1)
                   + (row_south ? mc_net_pkg::mc_ep_id_t'(mc_net_pkg::mc_num_tiles_x_lp) : '0);

  always_comb
    begin
      ep_stb_o = '0;
      if (gnt_v_r && m_stb_i[gnt_id_r] && hit)
        ep_stb_o[ep_id] = 1'b1;
    end

  assign ep_we_o  = m_we_i[gnt_id_r];
  assign ep_adr_o = m_adr_i[gnt_id_r];
  assign ep_dat_o = m_dat_i[gnt_id_r];

  for (genvar i = 0; i < num_m_lp; i++)
    begin : m_rsp
      assign m_ack_o[i] = gnt_v_r & (gnt_id_r == i) & ack_any;
      assign m_err_o[i] = gnt_v_r & (gnt_id_r == i) & err_r;
      assign m_dat_o[i] = ep_dat_i[ep_id];
    end

endmodule

// ==== mc_link_master.sv ====
`timescale 1ns/1ps

module mc_link_master
  (input                            blackparrot_clk
  ,input                            reset_i

  ,input                            req_v_i
  ,input  mc_link_pkg::mc_op_t      req_op_i
  ,input  mc_link_pkg::mc_x_cord_t  req_x_i
  ,input  mc_link_pkg::mc_y_cord_t  req_y_i
  ,input  mc_link_pkg::mc_addr_t    req_addr_i
  ,input  mc_link_pkg::mc_data_t    req_data_i
  ,output logic                     req_ready_o

  ,output logic                     rsp_v_o
  ,output mc_link_pkg::mc_op_t      rsp_op_o
  ,output logic                     rsp_err_o
  ,output mc_link_pkg::mc_data_t    rsp_data_o
  ,input                            rsp_ready_i

  ,output logic                     wb_cyc_o
  ,output logic                     wb_stb_o
  ,output logic                     wb_we_o
  ,output mc_link_pkg::mc_x_cord_t  wb_x_o
  ,output mc_link_pkg::mc_y_cord_t  wb_y_o
  ,output mc_link_pkg::mc_addr_t    wb_adr_o
  ,output mc_link_pkg::mc_data_t    wb_dat_o
  ,input                            wb_ack_i
  ,input                            wb_err_i
  ,input  mc_link_pkg::mc_data_t    wb_dat_i
  );

  localparam int els_lp       = mc_net_pkg::mc_req_fifo_els_lp;
  localparam int ptr_width_lp = $clog2(els_lp);
  localparam int cnt_width_lp = $clog2(els_lp + 1);

  typedef enum logic [1:0] {e_idle, e_busy, e_held} state_e;

  state_e state_r;
  state_e state_n;

  mc_link_pkg::mc_op_t     fifo_op_r   [els_lp];
  mc_link_pkg::mc_x_cord_t fifo_x_r    [els_lp];
  mc_link_pkg::mc_y_cord_t fifo_y_r    [els_lp];
  mc_link_pkg::mc_addr_t   fifo_addr_r [els_lp];
  mc_link_pkg::mc_data_t   fifo_data_r [els_lp];

  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    enq;
  logic                    deq;

  mc_link_pkg::mc_op_t     rsp_op_r;
  logic                    rsp_err_r;
  mc_link_pkg::mc_data_t   rsp_data_r;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(els_lp - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign req_ready_o = (count_r != cnt_width_lp'(els_lp));
  assign enq = req_v_i & req_ready_o;
  // Head leaves the buffer when its bus cycle ends
  assign deq = (state_r == e_busy) & (wb_ack_i | wb_err_i);

  ////////////////////////////////////////////////////////////////////
  // Request buffer

  always_ff @(posedge blackparrot_clk)
    begin
      if (enq)
        begin
          fifo_op_r[wr_ptr_r]   <= req_op_i;
          fifo_x_r[wr_ptr_r]    <= req_x_i;
          fifo_y_r[wr_ptr_r]    <= req_y_i;
          fifo_addr_r[wr_ptr_r] <= req_addr_i;
          fifo_data_r[wr_ptr_r] <= req_data_i;
        end
    end

  always_ff @(posedge blackparrot_clk)
    begin
      if (reset_i)
        begin
          wr_ptr_r <= '0;
          rd_ptr_r <= '0;
          count_r  <= '0;
        end
      else
        begin
          if (enq)
            wr_ptr_r <= next_ptr(wr_ptr_r);
          if (deq)
            rd_ptr_r <= next_ptr(rd_ptr_r);
          case ({enq, deq})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
          endcase
        end
    end

  ////////////////////////////////////////////////////////////////////
  // Bus cycle control

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        e_idle:  if (count_r != '0) state_n = e_busy;
        e_busy:  if (wb_ack_i | wb_err_i) state_n = e_held;
        e_held:  if (rsp_ready_i) state_n = e_idle;
        default: state_n = e_idle;
      endcase
    end

  always_ff @(posedge blackparrot_clk)
    begin
      if (reset_i)
        state_r <= e_idle;
      else
        state_r <= state_n;
    end

  assign wb_cyc_o = (state_r == e_busy);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = (fifo_op_r[rd_ptr_r] == mc_link_pkg::mc_op_store_lp);
  assign wb_x_o   = fifo_x_r[rd_ptr_r];
  assign wb_y_o   = fifo_y_r[rd_ptr_r];
  assign wb_adr_o = fifo_addr_r[rd_ptr_r];
  assign wb_dat_o = fifo_data_r[rd_ptr_r];

  // Only a good load returns data
  always_ff @(posedge blackparrot_clk)
    begin
      if (deq)
        begin
          rsp_op_r   <= fifo_op_r[rd_ptr_r];
          rsp_err_r  <= wb_err_i;
          rsp_data_r <= (!wb_err_i && fifo_op_r[rd_ptr_r] == mc_link_pkg::mc_op_load_lp)
                        ? wb_dat_i : '0;
        end
    end

  assign rsp_v_o    = (state_r == e_held);
  assign rsp_op_o   = rsp_op_r;
  assign rsp_err_o  = rsp_err_r;
  assign rsp_data_o = rsp_data_r;

endmodule

// ==== mc_net_pkg.sv ====
package mc_net_pkg;

  ////////////////////////////////////////////////////////////////////
  // Bus topology

  localparam int mc_num_masters_lp   = 2;
  localparam int mc_num_endpoints_lp = 4;

  // Memory columns are 1 .. mc_num_tiles_x_lp
  localparam int mc_num_tiles_x_lp = 2;

  // Rows that carry memories
  localparam int mc_north_y_lp = 0;
  localparam int mc_south_y_lp = 3;

  ////////////////////////////////////////////////////////////////////
  // Storage sizes

  localparam int mc_req_fifo_els_lp = 2;
  localparam int mc_mem_els_lp      = 256;

  // Column minus one, plus two on the south row
  typedef logic [1:0] mc_ep_id_t;

endpackage

// ==== mc_link_pkg.sv ====
package mc_link_pkg;

  ////////////////////////////////////////////////////////////////////
  // Packet fields

  // Word address inside one endpoint
  typedef logic [7:0] mc_addr_t;

  typedef logic [31:0] mc_data_t;

  // Destination coordinates
  typedef logic [1:0] mc_x_cord_t;
  typedef logic [1:0] mc_y_cord_t;

  typedef logic [0:0] mc_op_t;

  ////////////////////////////////////////////////////////////////////
  // Operation encodings

  localparam mc_op_t mc_op_load_lp  = 1'b0;
  localparam mc_op_t mc_op_store_lp = 1'b1;

endpackage
